//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_top_mips
FILELIST = top_mips.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- decode.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module decode (
	input  logic              clk,
	input  logic              reset,
	input  logic              debug_flag,
	input  mips_pkg::word_t   debug_addr,
	input  mips_pkg::if_id_t  if_id,
	input  mips_pkg::wb_bus_t wb,
	input  logic              flush,
	output mips_pkg::id_ex_t  id_ex,
	output logic              stall,
	output logic              jump,
	output logic              halt_seen,
	output mips_pkg::word_t   jump_target,
	output mips_pkg::word_t   reg_dbg
);

	mips_pkg::word_t      rf [0:31];
	logic [5:0]           opcode;
	logic [5:0]           funct;
	mips_pkg::reg_addr_t  rs;
	mips_pkg::reg_addr_t  rt;
	mips_pkg::exec_ctrl_t exec_c;
	mips_pkg::mem_ctrl_t  mem_c;
	mips_pkg::wb_ctrl_t   wb_c;
	mips_pkg::id_ex_t     id_ex_next;

	// Register read with write-through from write-back
	function automatic mips_pkg::word_t read_reg(input mips_pkg::reg_addr_t addr);
		if (addr == '0)
			return '0;
		if (wb.reg_write && wb.write_reg == addr)
			return wb.write_data;
		return rf[addr];
	endfunction

	assign opcode = if_id.instruction[31:26];
	assign funct  = if_id.instruction[5:0];
	assign rs     = if_id.instruction[25:21];
	assign rt     = if_id.instruction[20:16];

	// Register 0 is never stored
	always_ff @(posedge clk) begin
		if (wb.reg_write && wb.write_reg != '0)
			rf[wb.write_reg] <= wb.write_data;
	end

	always_ff @(posedge clk) begin
		reg_dbg <= read_reg(debug_addr[4:0]);
	end

	////////////////////////////////////////////////////////////
	// Control decoder
	////////////////////////////////////////////////////////////
	always_comb begin
		exec_c = '0;
		mem_c  = '0;
		wb_c   = '0;
		case (opcode)
			`MIPS_OP_RTYPE: begin
				exec_c.reg_dst_rd = 1'b1;
				wb_c.reg_write    = 1'b1;
				case (funct)
					`MIPS_FN_ADD: exec_c.alu_op = `MIPS_ALU_ADD;
					`MIPS_FN_SUB: exec_c.alu_op = `MIPS_ALU_SUB;
					`MIPS_FN_AND: exec_c.alu_op = `MIPS_ALU_AND;
					`MIPS_FN_OR:  exec_c.alu_op = `MIPS_ALU_OR;
					`MIPS_FN_SLT: exec_c.alu_op = `MIPS_ALU_SLT;
					`MIPS_FN_SLL: begin
						exec_c.alu_op         = `MIPS_ALU_SLL;
						exec_c.shift_by_shamt = 1'b1;
					end
					default: wb_c.reg_write = 1'b0;
				endcase
			end
			`MIPS_OP_ADDI: begin
				exec_c.alu_src_imm = 1'b1;
				wb_c.reg_write     = 1'b1;
			end
			`MIPS_OP_LW: begin
				exec_c.alu_src_imm = 1'b1;
				mem_c.mem_read     = 1'b1;
				wb_c.reg_write     = 1'b1;
				wb_c.mem_to_reg    = 1'b1;
			end
			`MIPS_OP_SW: begin
				exec_c.alu_src_imm = 1'b1;
				mem_c.mem_write    = 1'b1;
			end
			`MIPS_OP_BEQ: begin
				exec_c.alu_op = `MIPS_ALU_SUB;
				mem_c.branch  = 1'b1;
			end
			`MIPS_OP_HALT: mem_c.halt = 1'b1;
			default: ;
		endcase
	end

	// Jumps are pseudo-direct within the current 256 MB region
	assign jump        = opcode == `MIPS_OP_J;
	assign halt_seen   = opcode == `MIPS_OP_HALT;
	assign jump_target = {if_id.pc_plus4[31:28], if_id.instruction[25:0], 2'b00};

	// Load-use hazard against the rt of a load in execute
	assign stall = id_ex.mem.mem_read && id_ex.rt != '0 &&
		(id_ex.rt == rs || id_ex.rt == rt);

	always_comb begin
		id_ex_next.pc_plus4 = if_id.pc_plus4;
		id_ex_next.reg1     = read_reg(rs);
		id_ex_next.reg2     = read_reg(rt);
		id_ex_next.imm      = {{16{if_id.instruction[15]}}, if_id.instruction[15:0]};
		id_ex_next.rs       = rs;
		id_ex_next.rt       = rt;
		id_ex_next.rd       = if_id.instruction[15:11];
		id_ex_next.shamt    = if_id.instruction[10:6];
		id_ex_next.exec     = exec_c;
		id_ex_next.mem      = mem_c;
		id_ex_next.wb       = wb_c;
	end

	////////////////////////////////////////////////////////////
	// Decode/execute register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset)
			id_ex <= '0;
		else if (!debug_flag) begin
			// Bubble on flush or stall
			if (flush || stall)
				id_ex <= '0;
			else
				id_ex <= id_ex_next;
		end
	end

	// Register 0 always reaches execute as zero
	a_r0_kept: assert property (@(posedge clk) disable iff (reset)
		(id_ex.rs != '0 || id_ex.reg1 == '0) && (id_ex.rt != '0 || id_ex.reg2 == '0));

endmodule

//--- execute.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module execute (
	input  logic              clk,
	input  logic              reset,
	input  mips_pkg::id_ex_t  id_ex,
	input  mips_pkg::ex_mem_t fwd_mem,
	input  mips_pkg::wb_bus_t fwd_wb,
	input  logic              flush,
	output mips_pkg::ex_mem_t ex_mem
);

	mips_pkg::word_t src_a;
	mips_pkg::word_t src_b;
	mips_pkg::word_t op_a;
	mips_pkg::word_t op_b;
	mips_pkg::word_t alu_out;

	// Newest producer wins, register 0 is never forwarded
	function automatic mips_pkg::word_t forward(
		input mips_pkg::reg_addr_t src,
		input mips_pkg::word_t     value,
		input mips_pkg::ex_mem_t   m,
		input mips_pkg::wb_bus_t   w
	);
		if (src == '0)
			return value;
		if (m.wb.reg_write && !m.mem.mem_read && m.write_reg == src)
			return m.alu_out;
		if (w.reg_write && w.write_reg == src)
			return w.write_data;
		return value;
	endfunction

	always_comb begin
		src_a = forward(id_ex.rs, id_ex.reg1, fwd_mem, fwd_wb);
		src_b = forward(id_ex.rt, id_ex.reg2, fwd_mem, fwd_wb);
	end

	// sll shifts rt by shamt, so shamt takes the A side
	assign op_a = id_ex.exec.shift_by_shamt ? {27'd0, id_ex.shamt} : src_a;
	assign op_b = id_ex.exec.alu_src_imm ? id_ex.imm : src_b;

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////
	always_comb begin
		case (id_ex.exec.alu_op)
			`MIPS_ALU_ADD: alu_out = op_a + op_b;
			`MIPS_ALU_SUB: alu_out = op_a - op_b;
			`MIPS_ALU_AND: alu_out = op_a & op_b;
			`MIPS_ALU_OR:  alu_out = op_a | op_b;
			`MIPS_ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
			`MIPS_ALU_SLL: alu_out = op_b << op_a[4:0];
			default:       alu_out = '0;
		endcase
	end

	// Execute/memory register
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			ex_mem <= '0;
		end else begin
			ex_mem.branch_target <= id_ex.pc_plus4 + {id_ex.imm[29:0], 2'b00};
			ex_mem.alu_out       <= alu_out;
			ex_mem.zero          <= alu_out == '0;
			// Store data is rt after forwarding
			ex_mem.store_data    <= src_b;
			ex_mem.write_reg     <= id_ex.exec.reg_dst_rd ? id_ex.rd : id_ex.rt;
			ex_mem.mem           <= id_ex.mem;
			ex_mem.wb            <= id_ex.wb;
		end
	end

endmodule

//--- instruction_fetch.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module instruction_fetch (
	input  logic             clk,
	input  logic             reset,
	input  logic             debug_flag,
	input  logic             debug_we,
	input  mips_pkg::word_t  debug_addr,
	input  mips_pkg::word_t  debug_data,
	input  logic             stall,
	input  logic             jump,
	input  mips_pkg::word_t  jump_target,
	input  logic             branch_taken,
	input  mips_pkg::word_t  branch_target,
	input  logic             halt_seen,
	output mips_pkg::if_id_t if_id,
	output mips_pkg::word_t  pc
);

	localparam int IMEM_AW = $clog2(`MIPS_IMEM_DEPTH);

	mips_pkg::word_t imem [0:`MIPS_IMEM_DEPTH-1];
	mips_pkg::word_t pc_plus4;
	mips_pkg::word_t instruction;
	logic hold;

	assign pc_plus4 = pc + 32'd4;
	assign instruction = imem[pc[IMEM_AW+1:2]];
	// Halt stays in decode so the PC never moves past it
	assign hold = stall || halt_seen;

	// Program load, debug_addr is a word index
	always_ff @(posedge clk) begin
		if (debug_flag && debug_we)
			imem[debug_addr[IMEM_AW-1:0]] <= debug_data;
	end

	////////////////////////////////////////////////////////////
	// PC and fetch/decode register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			pc    <= '0;
			if_id <= '0;
		end else if (!debug_flag) begin
			if (branch_taken) begin
				pc    <= branch_target;
				if_id <= '0;
			end else if (!hold) begin
				if (jump) begin
					// Slot after the jump is dropped
					pc    <= jump_target;
					if_id <= '0;
				end else begin
					pc                <= pc_plus4;
					if_id.pc_plus4    <= pc_plus4;
					if_id.instruction <= instruction;
				end
			end
		end
	end

	// Load-use stall and debug must freeze the PC
	a_pc_hold: assert property (@(posedge clk) disable iff (reset)
		debug_flag || (stall && !branch_taken) |=> pc == $past(pc));

endmodule

//--- memory.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module memory (
	input  logic              clk,
	input  logic              reset,
	input  logic              debug_flag,
	input  mips_pkg::word_t   debug_addr,
	input  mips_pkg::ex_mem_t ex_mem,
	output mips_pkg::mem_wb_t mem_wb,
	output logic              branch_taken,
	output mips_pkg::word_t   branch_target,
	output mips_pkg::word_t   mem_dbg,
	output logic              halt_flag
);

	localparam int DMEM_AW = $clog2(`MIPS_DMEM_DEPTH);

	mips_pkg::word_t dmem [0:`MIPS_DMEM_DEPTH-1];
	logic [DMEM_AW-1:0] mem_idx;

	// Byte address from the ALU, word aligned
	assign mem_idx = ex_mem.alu_out[DMEM_AW+1:2];

	assign branch_taken  = ex_mem.mem.branch && ex_mem.zero;
	assign branch_target = ex_mem.branch_target;

	always_ff @(posedge clk) begin
		if (ex_mem.mem.mem_write && !debug_flag)
			dmem[mem_idx] <= ex_mem.store_data;
	end

	// Debug read, debug_addr is a word index here
	always_ff @(posedge clk) begin
		mem_dbg <= dmem[debug_addr[DMEM_AW-1:0]];
	end

	////////////////////////////////////////////////////////////
	// Memory/write-back register and halt
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			mem_wb    <= '0;
			halt_flag <= 1'b0;
		end else if (!debug_flag) begin
			mem_wb.read_data <= dmem[mem_idx];
			mem_wb.alu_out   <= ex_mem.alu_out;
			mem_wb.write_reg <= ex_mem.write_reg;
			mem_wb.wb        <= ex_mem.wb;
			// Sticky until reset
			if (ex_mem.mem.halt)
				halt_flag <= 1'b1;
		end
	end

	a_rw_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(ex_mem.mem.mem_read && ex_mem.mem.mem_write));

endmodule

//--- mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Memory depths in 32-bit words
`define MIPS_IMEM_DEPTH 256
`define MIPS_DMEM_DEPTH 256

////////////////////////////////////////////////////////////
// Opcodes, instruction bits 31:26
////////////////////////////////////////////////////////////
`define MIPS_OP_RTYPE 6'h00
`define MIPS_OP_ADDI  6'h08
`define MIPS_OP_LW    6'h23
`define MIPS_OP_SW    6'h2b
`define MIPS_OP_BEQ   6'h04
`define MIPS_OP_J     6'h02
`define MIPS_OP_HALT  6'h3f

// R-type funct field, bits 5:0
`define MIPS_FN_ADD 6'h20
`define MIPS_FN_SUB 6'h22
`define MIPS_FN_AND 6'h24
`define MIPS_FN_OR  6'h25
`define MIPS_FN_SLT 6'h2a
`define MIPS_FN_SLL 6'h00

// ALU operations
`define MIPS_ALU_ADD 3'd0
`define MIPS_ALU_SUB 3'd1
`define MIPS_ALU_AND 3'd2
`define MIPS_ALU_OR  3'd3
`define MIPS_ALU_SLT 3'd4
`define MIPS_ALU_SLL 3'd5

`endif

//--- mips_pkg.sv
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [2:0]  alu_op_t;

	////////////////////////////////////////////////////////////
	// Control groups, one per consuming stage
	////////////////////////////////////////////////////////////
	typedef struct packed {
		alu_op_t alu_op;
		logic    alu_src_imm;
		logic    reg_dst_rd;
		logic    shift_by_shamt;
	} exec_ctrl_t;

	typedef struct packed {
		logic mem_read;
		logic mem_write;
		logic branch;
		logic halt;
	} mem_ctrl_t;

	// reg_write is the upper bit, mem_to_reg the lower
	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	////////////////////////////////////////////////////////////
	// Stage registers
	////////////////////////////////////////////////////////////
	typedef struct packed {
		word_t pc_plus4;
		word_t instruction;
	} if_id_t;

	typedef struct packed {
		word_t      pc_plus4;
		word_t      reg1;
		word_t      reg2;
		word_t      imm;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] shamt;
		exec_ctrl_t exec;
		mem_ctrl_t  mem;
		wb_ctrl_t   wb;
	} id_ex_t;

	typedef struct packed {
		word_t     branch_target;
		word_t     alu_out;
		logic      zero;
		word_t     store_data;
		reg_addr_t write_reg;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
	} ex_mem_t;

	typedef struct packed {
		word_t     read_data;
		word_t     alu_out;
		reg_addr_t write_reg;
		wb_ctrl_t  wb;
	} mem_wb_t;

	// Result returned to the register file and the forwarding logic
	typedef struct packed {
		logic      reg_write;
		reg_addr_t write_reg;
		word_t     write_data;
	} wb_bus_t;

endpackage

//--- tb_top_mips.sv
`timescale 1ns/1ps

module tb_top_mips;

	localparam int TV_DEPTH      = 1024;
	localparam int RESET_CYCLES  = 5;
	localparam int SETTLE_CYCLES = 5;

	logic            clk;
	logic            reset;
	logic            debug_flag;
	logic            debug_we;
	mips_pkg::word_t debug_addr;
	mips_pkg::word_t debug_data;
	mips_pkg::word_t pc;
	mips_pkg::word_t reg_dbg;
	mips_pkg::word_t mem_dbg;
	logic            halt_flag;

	mips_pkg::word_t tv [0:TV_DEPTH-1];
	int              tv_idx;
	int              cur_test;
	int              checks;
	int              errors;
	int              watchdog_cycles;
	logic            watchdog_armed;

	top_mips DUT (
		.clk        (clk),
		.reset      (reset),
		.debug_flag (debug_flag),
		.debug_we   (debug_we),
		.debug_addr (debug_addr),
		.debug_data (debug_data),
		.pc         (pc),
		.reg_dbg    (reg_dbg),
		.mem_dbg    (mem_dbg),
		.halt_flag  (halt_flag)
	);

	always #4 clk = ~clk;

	task automatic check_value(input string name, input mips_pkg::word_t got,
		input mips_pkg::word_t exp);
		checks++;
		assert (got === exp) else begin
			$display("FAILED %s in test %0d: got %h, expected %h", name, cur_test, got, exp);
			errors++;
		end
	endtask

	task automatic next_word(output mips_pkg::word_t w);
		w = tv[tv_idx];
		tv_idx++;
	endtask

	// Cycle budget of all tests, with room for reset, load and readback
	function automatic int watchdog_budget(input int num_tests);
		int idx;
		int total;
		int nprog;
		int nchk;
		idx   = 1;
		total = 100;
		for (int t = 0; t < num_tests; t++) begin
			nprog = int'(tv[idx]);
			nchk  = int'(tv[idx+3]) + int'(tv[idx+4]);
			total += int'(tv[idx+1]) + nprog + 3 * nchk + 30;
			idx   += 5 + nprog + 2 * nchk;
		end
		return total;
	endfunction

	task automatic reset_core();
		@(posedge clk);
		reset      <= 1'b1;
		debug_flag <= 1'b1;
		debug_we   <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic load_word(input int addr, input mips_pkg::word_t data);
		@(posedge clk);
		debug_we   <= 1'b1;
		debug_addr <= addr;
		debug_data <= data;
	endtask

	// Debug outputs are registered, so sample one cycle after the address
	task automatic read_back(input bit is_reg, input mips_pkg::word_t addr,
		output mips_pkg::word_t value);
		@(posedge clk);
		debug_addr <= addr;
		@(posedge clk);
		@(negedge clk);
		value = is_reg ? reg_dbg : mem_dbg;
	endtask

	////////////////////////////////////////////////////////////
	// One test record
	////////////////////////////////////////////////////////////
	task automatic run_test();
		int              nprog;
		int              limit;
		int              nregs;
		int              nmem;
		int              cycles;
		mips_pkg::word_t w;
		mips_pkg::word_t halt_addr;
		mips_pkg::word_t pc_at_halt;
		mips_pkg::word_t a;
		mips_pkg::word_t exp;
		mips_pkg::word_t got;
		next_word(w);
		nprog = int'(w);
		next_word(w);
		limit = int'(w);
		next_word(halt_addr);
		next_word(w);
		nregs = int'(w);
		next_word(w);
		nmem = int'(w);

		reset_core();
		for (int i = 0; i < nprog; i++) begin
			next_word(w);
			load_word(i, w);
		end
		@(posedge clk);
		debug_we <= 1'b0;
		@(negedge clk);
		check_value("halt_flag", {31'd0, halt_flag}, 32'd0);
		check_value("pc", pc, 32'd0);

		@(posedge clk);
		debug_flag <= 1'b0;
		cycles = 0;
		while (!halt_flag && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		checks++;
		assert (halt_flag) else begin
			$display("Test %0d: halt_flag did not rise within %0d cycles", cur_test, limit);
			errors++;
		end
		pc_at_halt = pc;
		check_value("pc", pc_at_halt, halt_addr + 32'd4);

		// Halt must be sticky and the PC frozen
		repeat (SETTLE_CYCLES) @(negedge clk);
		check_value("halt_flag", {31'd0, halt_flag}, 32'd1);
		check_value("pc", pc, halt_addr + 32'd4);

		@(posedge clk);
		debug_flag <= 1'b1;
		for (int i = 0; i < nregs; i++) begin
			next_word(a);
			next_word(exp);
			read_back(1'b1, a, got);
			check_value($sformatf("reg_dbg[%0d]", a), got, exp);
		end
		for (int i = 0; i < nmem; i++) begin
			next_word(a);
			next_word(exp);
			read_back(1'b0, a, got);
			check_value($sformatf("mem_dbg[%0d]", a), got, exp);
		end
	endtask

	initial begin
		int num_tests;
		clk            = 1'b0;
		reset          = 1'b1;
		debug_flag     = 1'b1;
		debug_we       = 1'b0;
		debug_addr     = '0;
		debug_data     = '0;
		checks         = 0;
		errors         = 0;
		cur_test       = 0;
		watchdog_armed = 1'b0;
		num_tests      = 0;

		$readmemh("top_mips_tests.txt", tv);
		if ($isunknown(tv[0]) || tv[0] == '0) begin
			$display("Test file top_mips_tests.txt is missing or holds no tests");
			errors++;
		end else begin
			num_tests = int'(tv[0]);
		end

		watchdog_cycles = watchdog_budget(num_tests);
		watchdog_armed  = 1'b1;
		tv_idx = 1;
		for (int t = 0; t < num_tests; t++) begin
			cur_test = t;
			run_test();
		end

		@(posedge clk);
		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Watchdog
	initial begin
		wait (watchdog_armed);
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
		$display("Checks: %0d  Errors: %0d", checks, errors + 1);
		$display("Errors found");
		$finish;
	end

endmodule

//--- top_mips.f
+incdir+.
mips_pkg.sv
instruction_fetch.sv
decode.sv
execute.sv
memory.sv
top_mips.sv
tb_top_mips.sv

//--- top_mips.sv
`timescale 1ns/1ps

module top_mips (
	input  logic            clk,
	input  logic            reset,
	input  logic            debug_flag,
	input  logic            debug_we,
	input  mips_pkg::word_t debug_addr,
	input  mips_pkg::word_t debug_data,
	output mips_pkg::word_t pc,
	output mips_pkg::word_t reg_dbg,
	output mips_pkg::word_t mem_dbg,
	output logic            halt_flag
);

	mips_pkg::if_id_t  if_id;
	mips_pkg::id_ex_t  id_ex;
	mips_pkg::ex_mem_t ex_mem;
	mips_pkg::mem_wb_t mem_wb;
	mips_pkg::wb_bus_t wb;
	mips_pkg::word_t   jump_target;
	mips_pkg::word_t   branch_target;
	logic stall;
	logic jump;
	logic halt_seen;
	logic branch_taken;

	////////////////////////////////////////////////////////////
	// Write-back
	////////////////////////////////////////////////////////////
	always_comb begin
		wb.reg_write  = mem_wb.wb.reg_write;
		wb.write_reg  = mem_wb.write_reg;
		wb.write_data = mem_wb.wb.mem_to_reg ? mem_wb.read_data : mem_wb.alu_out;
	end

	instruction_fetch u_instruction_fetch (
		.clk           (clk),
		.reset         (reset),
		.debug_flag    (debug_flag),
		.debug_we      (debug_we),
		.debug_addr    (debug_addr),
		.debug_data    (debug_data),
		.stall         (stall),
		.jump          (jump),
		.jump_target   (jump_target),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.halt_seen     (halt_seen),
		.if_id         (if_id),
		.pc            (pc)
	);

	decode u_decode (
		.clk         (clk),
		.reset       (reset),
		.debug_flag  (debug_flag),
		.debug_addr  (debug_addr),
		.if_id       (if_id),
		.wb          (wb),
		.flush       (branch_taken),
		.id_ex       (id_ex),
		.stall       (stall),
		.jump        (jump),
		.halt_seen   (halt_seen),
		.jump_target (jump_target),
		.reg_dbg     (reg_dbg)
	);

	// Forwarding taps come straight off the two later stage registers
	execute u_execute (
		.clk     (clk),
		.reset   (reset),
		.id_ex   (id_ex),
		.fwd_mem (ex_mem),
		.fwd_wb  (wb),
		.flush   (branch_taken),
		.ex_mem  (ex_mem)
	);

	memory u_memory (
		.clk           (clk),
		.reset         (reset),
		.debug_flag    (debug_flag),
		.debug_addr    (debug_addr),
		.ex_mem        (ex_mem),
		.mem_wb        (mem_wb),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.mem_dbg       (mem_dbg),
		.halt_flag     (halt_flag)
	);

endmodule

//--- top_mips_tests.txt
// Test count, then per test: word count, cycle limit, halt address, register checks,
// memory checks; then program words, (register, value) and (word address, value) pairs
04

// Forwarding through dependent R-type and addi, slt signed, sll, write to $0
0c 28 0000002c 0b 00
20010005 20220003 00221820 00612022 00822824 00653025
0083382a 00014100 2009ffff 0120502a 00210020 fc000000
00 00000000 01 00000005 02 00000008 03 0000000d
04 00000008 05 00000008 06 0000000d 07 00000001
08 00000050 09 ffffffff 0a 00000001

// Store then load, load-use stalls on rs and rt
09 28 00000020 05 03
20011234 ac010008 8c020008 00421820 ac03000c 8c04000c
20860001 ac060010 fc000000
01 00001234 02 00001234 03 00002468 04 00002468 06 00002469
02 00001234 03 00002468 04 00002469

// Not-taken beq, then a taken beq over three slots
0d 28 00000030 05 00
20010007 20020007 20030001 20040002 20050003 10230002 20060011
10220003 20030099 20040099 20050099 20670020 fc000000
03 00000001 04 00000002 05 00000003 06 00000011 07 00000021

// Jump over one slot, $0 is never forwarded
09 28 00000020 05 00
20010001 20020022 08000005 20010055 20020066 20230002 20000009
00032020 fc000000
00 00000000 01 00000001 02 00000022 03 00000003 04 00000003
